/* verilog/cpuPkg.sv */
package cpuPkg;

    localparam int dataWidth = 16;
    localparam int addrWidth = 12;

    // ======================================================================
    // Instruction encodings
    // ======================================================================

    typedef enum logic [3:0] {
        opLoad    = 4'b0000,
        opStore   = 4'b0001,
        opJump    = 4'b0010,
        opBranchZ = 4'b0100,
        opReg     = 4'b1000,
        opAddI    = 4'b1100,
        opAndI    = 4'b1101,
        opHalt    = 4'b1111
    } opcodeT;

    // Register-form function field is one-hot
    typedef enum logic [8:0] {
        fnMoveTo   = 9'b0_0000_0001,
        fnMoveFrom = 9'b0_0000_0010,
        fnAdd      = 9'b0_0000_0100,
        fnSub      = 9'b0_0000_1000,
        fnAnd      = 9'b0_0001_0000,
        fnOr       = 9'b0_0010_0000,
        fnNot      = 9'b0_0100_0000,
        fnNop      = 9'b0_1000_0000
    } funcT;

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluNotA  = 3'd4,
        aluPassB = 3'd5
    } aluOpT;

    typedef struct packed {
        opcodeT                opcode;
        logic [addrWidth-1:0]  addr;
    } addrFormT;

    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] regIdx;
        funcT       func;
    } regFormT;

    typedef union packed {
        addrFormT addrForm;
        regFormT  regForm;
    } instrT;

    // Operand and PC source selects
    localparam logic [1:0] srcBReg      = 2'd0;
    localparam logic [1:0] srcBOne      = 2'd1;
    localparam logic [1:0] srcBImm      = 2'd2;
    localparam logic [1:0] pcFromAlu    = 2'd0;
    localparam logic [1:0] pcFromJump   = 2'd1;
    localparam logic [1:0] pcFromBranch = 2'd2;

    // ======================================================================
    // Buses between blocks
    // ======================================================================

    typedef struct packed {
        logic       pcWrite;
        logic       branch;
        logic       iOrD;
        logic       irWrite;
        logic       regWrite;
        logic       regDst;
        logic       dataFromMem;
        logic       aluSrcA;
        logic [1:0] aluSrcB;
        aluOpT      aluOp;
        logic [1:0] pcSrc;
        logic       memRead;
        logic       memWrite;
    } ctrlT;

    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
        logic                 write;
    } memReqT;

    typedef struct packed {
        opcodeT opcode;
        logic   zero;
    } statusT;

endpackage

/* verilog/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  cpuPkg::aluOpT                op,
    output logic [cpuPkg::dataWidth-1:0] result,
    output logic                         zero
);

    always_comb begin
        case (op)
            cpuPkg::aluAdd:   result = a + b;
            cpuPkg::aluSub:   result = a - b;
            cpuPkg::aluAnd:   result = a & b;
            cpuPkg::aluOr:    result = a | b;
            cpuPkg::aluNotA:  result = ~a;
            cpuPkg::aluPassB: result = b;
            default:          result = b;
        endcase
    end

    // Branch-if-zero tests this flag directly
    assign zero = (result == '0);

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [2:0]                   readAddr,
    input  logic [2:0]                   writeAddr,
    input  logic                         writeEn,
    input  logic [cpuPkg::dataWidth-1:0] writeData,
    output logic [cpuPkg::dataWidth-1:0] readData0,
    output logic [cpuPkg::dataWidth-1:0] readData1
);

    logic [cpuPkg::dataWidth-1:0] regs [8];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Register 0 is the accumulator and always feeds the A side
    assign readData0 = regs[0];
    assign readData1 = regs[readAddr];

endmodule

/* verilog/cpuDatapath.sv */
`timescale 1ns/1ps

module cpuDatapath #(
    parameter logic [cpuPkg::addrWidth-1:0] resetPc = '0
) (
    input  logic                         clk,
    input  logic                         arstN,
    input  cpuPkg::ctrlT                 ctrl,
    input  logic [cpuPkg::dataWidth-1:0] memRdata,
    input  logic                         memDone,
    output cpuPkg::memReqT               memBus,
    output cpuPkg::statusT               status,
    output cpuPkg::instrT                instr
);

    logic [cpuPkg::addrWidth-1:0] pc;
    logic [cpuPkg::addrWidth-1:0] pcNext;
    logic [cpuPkg::addrWidth-1:0] targetAddr;
    cpuPkg::instrT                ir;
    logic [cpuPkg::dataWidth-1:0] mdr;
    logic [cpuPkg::dataWidth-1:0] aReg;
    logic [cpuPkg::dataWidth-1:0] bReg;
    logic [cpuPkg::dataWidth-1:0] aluReg;
    logic [cpuPkg::dataWidth-1:0] rfData0;
    logic [cpuPkg::dataWidth-1:0] rfData1;
    logic [cpuPkg::dataWidth-1:0] rfWriteData;
    logic [2:0]                   rfReadAddr;
    logic [2:0]                   rfWriteAddr;
    logic [cpuPkg::dataWidth-1:0] aluA;
    logic [cpuPkg::dataWidth-1:0] aluB;
    logic [cpuPkg::dataWidth-1:0] aluResult;
    logic [cpuPkg::dataWidth-1:0] immExt;
    logic                         aluZero;
    logic                         pcLoad;

    // ======================================================================
    // Architectural registers
    // ======================================================================

    assign pcLoad = ctrl.pcWrite | (ctrl.branch & aluZero);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
            ir <= '0;
        end else begin
            if (pcLoad) begin
                pc <= pcNext;
            end
            // IR captures the fetched word on the done pulse
            if (ctrl.irWrite && memDone) begin
                ir <= memRdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        mdr    <= memRdata;
        aReg   <= rfData0;
        bReg   <= rfData1;
        aluReg <= aluResult;
    end

    // ======================================================================
    // Operand and address selection
    // ======================================================================

    // Move-to and all address-form instructions read the accumulator on the B side too
    assign rfReadAddr = (ir.regForm.opcode == cpuPkg::opReg &&
                         ir.regForm.func != cpuPkg::fnMoveTo) ? ir.regForm.regIdx : 3'd0;
    assign rfWriteAddr = ctrl.regDst ? ir.regForm.regIdx : 3'd0;
    assign rfWriteData = ctrl.dataFromMem ? mdr : aluReg;

    registerFile u_registerFile (
        .clk       (clk),
        .arstN     (arstN),
        .readAddr  (rfReadAddr),
        .writeAddr (rfWriteAddr),
        .writeEn   (ctrl.regWrite),
        .writeData (rfWriteData),
        .readData0 (rfData0),
        .readData1 (rfData1)
    );

    assign immExt = {{4{ir.addrForm.addr[11]}}, ir.addrForm.addr};
    assign aluA   = ctrl.aluSrcA ? {4'd0, pc} : aReg;

    always_comb begin
        case (ctrl.aluSrcB)
            cpuPkg::srcBOne: aluB = 16'd1;
            cpuPkg::srcBImm: aluB = immExt;
            default:         aluB = bReg;
        endcase
    end

    aluUnit u_aluUnit (
        .a      (aluA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign targetAddr = ir.addrForm.addr;

    always_comb begin
        case (ctrl.pcSrc)
            cpuPkg::pcFromJump,
            cpuPkg::pcFromBranch: pcNext = targetAddr;
            default:              pcNext = aluResult[cpuPkg::addrWidth-1:0];
        endcase
    end

    assign memBus.addr  = ctrl.iOrD ? ir.addrForm.addr : pc;
    assign memBus.wdata = aReg;
    assign memBus.write = ctrl.memWrite;

    assign status.opcode = ir.addrForm.opcode;
    assign status.zero   = aluZero;
    assign instr         = ir;

endmodule

/* verilog/cpuController.sv */
`timescale 1ns/1ps

module cpuController (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::statusT status,
    input  cpuPkg::instrT  instr,
    input  logic           memDone,
    output cpuPkg::ctrlT   ctrl,
    output logic           memStart,
    output logic           halted
);

    typedef enum logic [2:0] {
        stFetch,
        stFetchWait,
        stDecode,
        stExecute,
        stMemWait,
        stWriteBack,
        stHalt
    } stateT;

    stateT         state;
    stateT         stateNext;
    cpuPkg::aluOpT execOp;
    logic [1:0]    execSrcB;
    logic          writesReg;
    logic          toNamedReg;

    // ======================================================================
    // Instruction decode
    // ======================================================================

    // Anything not listed falls through as a no-op
    always_comb begin
        execOp     = cpuPkg::aluPassB;
        execSrcB   = cpuPkg::srcBReg;
        writesReg  = 1'b0;
        toNamedReg = 1'b0;
        case (status.opcode)
            cpuPkg::opAddI: begin
                execOp    = cpuPkg::aluAdd;
                execSrcB  = cpuPkg::srcBImm;
                writesReg = 1'b1;
            end
            cpuPkg::opAndI: begin
                execOp    = cpuPkg::aluAnd;
                execSrcB  = cpuPkg::srcBImm;
                writesReg = 1'b1;
            end
            cpuPkg::opReg: begin
                writesReg = 1'b1;
                case (instr.regForm.func)
                    cpuPkg::fnAdd:      execOp = cpuPkg::aluAdd;
                    cpuPkg::fnSub:      execOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd:      execOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:       execOp = cpuPkg::aluOr;
                    cpuPkg::fnNot:      execOp = cpuPkg::aluNotA;
                    cpuPkg::fnMoveTo:   toNamedReg = 1'b1;
                    cpuPkg::fnMoveFrom: execOp = cpuPkg::aluPassB;
                    default:            writesReg = 1'b0;
                endcase
            end
            default: begin
                writesReg = 1'b0;
            end
        endcase
    end

    // ======================================================================
    // State machine
    // ======================================================================

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stFetch;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        ctrl      = '0;
        case (state)
            stFetch: begin
                ctrl.memRead = 1'b1;
                stateNext    = stFetchWait;
            end
            stFetchWait: begin
                // PC plus one is ready for the done pulse
                ctrl.irWrite = 1'b1;
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = cpuPkg::srcBOne;
                ctrl.aluOp   = cpuPkg::aluAdd;
                ctrl.pcSrc   = cpuPkg::pcFromAlu;
                if (memDone) begin
                    ctrl.pcWrite = 1'b1;
                    stateNext    = stDecode;
                end
            end
            stDecode: begin
                stateNext = stExecute;
            end
            stExecute: begin
                ctrl.aluOp   = execOp;
                ctrl.aluSrcB = execSrcB;
                stateNext    = stWriteBack;
                case (status.opcode)
                    cpuPkg::opLoad: begin
                        ctrl.iOrD    = 1'b1;
                        ctrl.memRead = 1'b1;
                        stateNext    = stMemWait;
                    end
                    cpuPkg::opStore: begin
                        ctrl.iOrD     = 1'b1;
                        ctrl.memWrite = 1'b1;
                        stateNext     = stMemWait;
                    end
                    cpuPkg::opJump: begin
                        ctrl.pcWrite = 1'b1;
                        ctrl.pcSrc   = cpuPkg::pcFromJump;
                    end
                    cpuPkg::opBranchZ: begin
                        ctrl.branch = 1'b1;
                        ctrl.pcSrc  = cpuPkg::pcFromBranch;
                    end
                    cpuPkg::opHalt: begin
                        stateNext = stHalt;
                    end
                    default: begin
                        stateNext = stWriteBack;
                    end
                endcase
            end
            stMemWait: begin
                ctrl.iOrD = 1'b1;
                if (memDone) begin
                    ctrl.regWrite    = (status.opcode == cpuPkg::opLoad);
                    ctrl.dataFromMem = 1'b1;
                    stateNext        = stFetch;
                end
            end
            stWriteBack: begin
                ctrl.regWrite = writesReg;
                ctrl.regDst   = toNamedReg;
                stateNext     = stFetch;
            end
            stHalt: begin
                stateNext = stHalt;
            end
            default: begin
                stateNext = stFetch;
            end
        endcase
    end

    // Read and write strobes are only set on the cycle a request starts
    assign memStart = ctrl.memRead | ctrl.memWrite;
    assign halted   = (state == stHalt);

endmodule

/* verilog/memoryPort.sv */
`timescale 1ns/1ps

module memoryPort (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         start,
    input  cpuPkg::memReqT               reqIn,
    output logic                         done,
    output logic [cpuPkg::dataWidth-1:0] rdata,
    output logic                         memReq,
    input  logic                         memAck,
    input  logic [cpuPkg::dataWidth-1:0] memRdata,
    output cpuPkg::memReqT               memBus
);

    typedef enum logic [1:0] {
        phIdle,
        phWaitAck,
        phRelease
    } phaseT;

    phaseT phase;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase <= phIdle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (phase)
                phIdle:    if (start) phase <= phWaitAck;
                phWaitAck: if (memAck) phase <= phRelease;
                phRelease: begin
                    if (!memAck) begin
                        phase <= phIdle;
                        done  <= 1'b1;
                    end
                end
                default:   phase <= phIdle;
            endcase
        end
    end

    // Request held from start until the next one, read word held from the ack
    always_ff @(posedge clk) begin
        if (phase == phIdle && start) begin
            memBus <= reqIn;
        end
        if (phase == phWaitAck && memAck) begin
            rdata <= memRdata;
        end
    end

    assign memReq = (phase == phWaitAck);

endmodule

/* verilog/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop #(
    parameter logic [cpuPkg::addrWidth-1:0] resetPc = '0
) (
    input  logic                         clk,
    input  logic                         arstN,
    output logic                         memReq,
    output cpuPkg::memReqT               memBus,
    input  logic                         memAck,
    input  logic [cpuPkg::dataWidth-1:0] memRdata,
    output logic                         halted
);

    cpuPkg::ctrlT                 ctrl;
    cpuPkg::statusT               status;
    cpuPkg::instrT                instr;
    cpuPkg::memReqT               dpBus;
    logic                         memStart;
    logic                         memDone;
    logic [cpuPkg::dataWidth-1:0] readWord;

    cpuController u_cpuController (
        .clk      (clk),
        .arstN    (arstN),
        .status   (status),
        .instr    (instr),
        .memDone  (memDone),
        .ctrl     (ctrl),
        .memStart (memStart),
        .halted   (halted)
    );

    cpuDatapath #(
        .resetPc (resetPc)
    ) u_cpuDatapath (
        .clk      (clk),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .memRdata (readWord),
        .memDone  (memDone),
        .memBus   (dpBus),
        .status   (status),
        .instr    (instr)
    );

    memoryPort u_memoryPort (
        .clk      (clk),
        .arstN    (arstN),
        .start    (memStart),
        .reqIn    (dpBus),
        .done     (memDone),
        .rdata    (readWord),
        .memReq   (memReq),
        .memAck   (memAck),
        .memRdata (memRdata),
        .memBus   (memBus)
    );

endmodule

/* sim/memHandshake_assert.sv */
`timescale 1ns/1ps

module memHandshakeAssert (
    input logic           clk,
    input logic           arstN,
    input logic           memReq,
    input logic           memAck,
    input cpuPkg::memReqT memBus
);

    int assertFails = 0;

    // Address, data and direction hold for the whole request phase
    busStable: assert property (@(posedge clk) disable iff (!arstN)
        memReq && $past(memReq) |-> $stable(memBus))
    else begin
        assertFails++;
        $error("memBus changed while memReq was high");
    end

    noRiseOnAck: assert property (@(posedge clk) disable iff (!arstN)
        $rose(memReq) |-> !memAck && !$past(memAck))
    else begin
        assertFails++;
        $error("memReq rose while memAck was still high");
    end

    // A request only ends once the memory has answered it
    dropAfterAck: assert property (@(posedge clk) disable iff (!arstN)
        $fell(memReq) |-> $past(memAck))
    else begin
        assertFails++;
        $error("memReq dropped without an acknowledge");
    end

    quietInReset: assert property (@(posedge clk) !arstN |-> !memReq)
    else begin
        assertFails++;
        $error("memReq was high during reset");
    end

endmodule

bind cpuTop memHandshakeAssert u_memHandshakeAssert (
    .clk    (clk),
    .arstN  (arstN),
    .memReq (memReq),
    .memAck (memAck),
    .memBus (memBus)
);

/* sim/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

    localparam logic [cpuPkg::addrWidth-1:0] resetPc  = 12'h040;
    localparam logic [cpuPkg::addrWidth-1:0] dataBase = 12'h800;
    localparam int progLength    = 200;
    localparam int timeoutCycles = 40 * (progLength + 1) + 200;
    localparam int quietCycles   = 50;

    typedef enum logic [1:0] {
        rsIdle,
        rsDelay,
        rsAck
    } respStateT;

    logic                         clk;
    logic                         arstN;
    logic                         memReq;
    cpuPkg::memReqT               memBus;
    logic                         memAck;
    logic [cpuPkg::dataWidth-1:0] memRdata;
    logic                         halted;

    // Memory behind the DUT, and the copy the instruction-set model runs on
    logic [cpuPkg::dataWidth-1:0] mem       [4096];
    logic [cpuPkg::dataWidth-1:0] modelMem  [4096];
    logic [cpuPkg::dataWidth-1:0] modelRegs [8];
    logic [cpuPkg::addrWidth-1:0] modelPc;
    logic                         modelHalted;
    cpuPkg::memReqT               expectQ [$];
    bit                           fetchQ  [$];
    int unsigned                  ackDelay [512];

    respStateT      respState;
    cpuPkg::memReqT heldReq;
    int unsigned    delayLeft;

    int  errors          = 0;
    int  checks          = 0;
    int  reqCount        = 0;
    int  cycleCount      = 0;
    int  fetches         = 0;
    int  loads           = 0;
    int  stores          = 0;
    int  jumps           = 0;
    int  taken           = 0;
    int  notTaken        = 0;
    int  testsRun        = 0;
    int  testsFailed     = 0;
    int  testStartErrors = 0;
    bit  firstChecked    = 1'b0;

    cpuTop #(
        .resetPc (resetPc)
    ) u_cpuTop (
        .clk      (clk),
        .arstN    (arstN),
        .memReq   (memReq),
        .memBus   (memBus),
        .memAck   (memAck),
        .memRdata (memRdata),
        .halted   (halted)
    );

    always #2 clk = ~clk;

    // ======================================================================
    // Compare tasks and test bookkeeping
    // ======================================================================

    task automatic compareReq(input string name, input cpuPkg::memReqT expected,
                              input cpuPkg::memReqT actual);
        bit    bad;
        string expText;
        string actText;
        checks++;
        bad = (expected.addr !== actual.addr) || (expected.write !== actual.write);
        // Reads carry whatever sits in A, so only writes have meaningful data
        if (expected.write && (expected.wdata !== actual.wdata)) begin
            bad = 1'b1;
        end
        if (bad) begin
            errors++;
            expText = $sformatf("addr=%h wdata=%h write=%b",
                                expected.addr, expected.wdata, expected.write);
            actText = $sformatf("addr=%h wdata=%h write=%b",
                                actual.addr, actual.wdata, actual.write);
            $display("Error at %0d ns: %s expected %s, actual %s", $time, name,
                     expText, actText);
        end
    endtask

    task automatic compareFlag(input string name, input logic expected, input logic actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error at %0d ns: %s expected %b, actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errors == testStartErrors) begin
            $display("PASS %s", name);
        end else begin
            testsFailed++;
            $display("FAIL %s (%0d errors)", name, errors - testStartErrors);
        end
        testStartErrors = errors;
    endtask

    // ======================================================================
    // Program generation and instruction-set model
    // ======================================================================

    task automatic buildProgram();
        logic [cpuPkg::addrWidth-1:0] pc;
        logic [cpuPkg::addrWidth-1:0] lastAddr;
        logic [cpuPkg::addrWidth-1:0] target;
        logic [cpuPkg::addrWidth-1:0] imm;
        int                           pick;
        lastAddr = resetPc + 12'(progLength);
        for (int i = 0; i < progLength; i++) begin
            pc   = resetPc + 12'(i);
            pick = $urandom_range(0, 99);
            imm  = 12'($urandom);
            // Targets point forward and never past the halt word
            target = pc + 12'($urandom_range(1, 4));
            if (target > lastAddr) begin
                target = lastAddr;
            end
            if (pick < 10) begin
                mem[pc] = {cpuPkg::opLoad, dataBase + 12'($urandom_range(0, 63))};
            end else if (pick < 22) begin
                mem[pc] = {cpuPkg::opStore, dataBase + 12'($urandom_range(0, 63))};
            end else if (pick < 28) begin
                mem[pc] = {cpuPkg::opJump, target};
            end else if (pick < 38) begin
                mem[pc] = {cpuPkg::opBranchZ, target};
            end else if (pick < 50) begin
                mem[pc] = {cpuPkg::opAddI, imm};
            end else if (pick < 58) begin
                // A zero mask now and then gives the branches something to take
                if ($urandom_range(0, 2) == 0) begin
                    imm = 12'h000;
                end
                mem[pc] = {cpuPkg::opAndI, imm};
            end else begin
                // Bit 8 of the function field is unused and must act as a no-op
                mem[pc] = {cpuPkg::opReg, 3'($urandom_range(0, 7)),
                           9'(9'h001 << $urandom_range(0, 8))};
            end
        end
        mem[lastAddr] = {cpuPkg::opHalt, 12'h000};
    endtask

    task automatic expectRequest(input logic [cpuPkg::addrWidth-1:0] addr,
                                 input logic [cpuPkg::dataWidth-1:0] wdata,
                                 input logic write, input bit isFetch);
        cpuPkg::memReqT req;
        req.addr  = addr;
        req.wdata = wdata;
        req.write = write;
        expectQ.push_back(req);
        fetchQ.push_back(isFetch);
    endtask

    task automatic runModel(input logic [cpuPkg::addrWidth-1:0] fetchAddr);
        logic [cpuPkg::dataWidth-1:0] word;
        logic [3:0]                   op;
        logic [cpuPkg::addrWidth-1:0] field;
        logic [2:0]                   idx;
        logic [8:0]                   fn;
        word    = modelMem[fetchAddr];
        op      = word[15:12];
        field   = word[11:0];
        idx     = word[11:9];
        fn      = word[8:0];
        modelPc = fetchAddr + 12'd1;
        case (op)
            cpuPkg::opLoad: begin
                expectRequest(field, 16'h0000, 1'b0, 1'b0);
                modelRegs[0] = modelMem[field];
                loads++;
            end
            cpuPkg::opStore: begin
                expectRequest(field, modelRegs[0], 1'b1, 1'b0);
                modelMem[field] = modelRegs[0];
                stores++;
            end
            cpuPkg::opJump: begin
                modelPc = field;
                jumps++;
            end
            cpuPkg::opBranchZ: begin
                if (modelRegs[0] == 16'h0000) begin
                    modelPc = field;
                    taken++;
                end else begin
                    notTaken++;
                end
            end
            cpuPkg::opAddI: modelRegs[0] = modelRegs[0] + {{4{field[11]}}, field};
            cpuPkg::opAndI: modelRegs[0] = modelRegs[0] & {{4{field[11]}}, field};
            cpuPkg::opReg: begin
                case (fn)
                    cpuPkg::fnAdd:      modelRegs[0] = modelRegs[0] + modelRegs[idx];
                    cpuPkg::fnSub:      modelRegs[0] = modelRegs[0] - modelRegs[idx];
                    cpuPkg::fnAnd:      modelRegs[0] = modelRegs[0] & modelRegs[idx];
                    cpuPkg::fnOr:       modelRegs[0] = modelRegs[0] | modelRegs[idx];
                    cpuPkg::fnNot:      modelRegs[0] = ~modelRegs[0];
                    cpuPkg::fnMoveTo:   modelRegs[idx] = modelRegs[0];
                    cpuPkg::fnMoveFrom: modelRegs[0] = modelRegs[idx];
                    default:            ;
                endcase
            end
            cpuPkg::opHalt: modelHalted = 1'b1;
            default:        ;
        endcase
        if (!modelHalted) begin
            expectRequest(modelPc, 16'h0000, 1'b0, 1'b1);
        end
    endtask

    task automatic checkRequest(input cpuPkg::memReqT req);
        cpuPkg::memReqT expected;
        bit             isFetch;
        if (expectQ.size() == 0) begin
            errors++;
            $display("Unexpected memory request to %h at %0d ns after the model halted",
                     req.addr, $time);
        end else begin
            expected = expectQ.pop_front();
            isFetch  = fetchQ.pop_front();
            compareReq(isFetch ? "memBus (fetch)" : "memBus (data)", expected, req);
            if (isFetch) begin
                fetches++;
                runModel(expected.addr);
            end
        end
        firstChecked = 1'b1;
    endtask

    // ======================================================================
    // Memory responder
    // ======================================================================

    always @(posedge clk) begin
        if (!arstN) begin
            respState = rsIdle;
            memAck <= 1'b0;
        end else begin
            case (respState)
                rsIdle: begin
                    if (memReq) begin
                        heldReq = memBus;
                        checkRequest(heldReq);
                        if (heldReq.write) begin
                            mem[heldReq.addr] = heldReq.wdata;
                        end
                        delayLeft = ackDelay[reqCount % 512];
                        reqCount++;
                        if (delayLeft == 0) begin
                            memAck    <= 1'b1;
                            memRdata  <= mem[heldReq.addr];
                            respState = rsAck;
                        end else begin
                            respState = rsDelay;
                        end
                    end
                end
                rsDelay: begin
                    delayLeft--;
                    if (delayLeft == 0) begin
                        memAck    <= 1'b1;
                        memRdata  <= mem[heldReq.addr];
                        respState = rsAck;
                    end
                end
                default: begin
                    if (!memReq) begin
                        memAck    <= 1'b0;
                        respState = rsIdle;
                    end
                end
            endcase
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        int reqAtHalt;
        int assertFails;
        void'($urandom(32'h7588_1101));
        clk      = 1'b0;
        arstN    = 1'b1;
        memAck   = 1'b0;
        memRdata = '0;
        for (int a = 0; a < 4096; a++) begin
            mem[a] = 16'($urandom);
        end
        for (int d = 0; d < 512; d++) begin
            ackDelay[d] = $urandom_range(0, 5);
        end
        buildProgram();
        for (int a = 0; a < 4096; a++) begin
            modelMem[a] = mem[a];
        end
        for (int r = 0; r < 8; r++) begin
            modelRegs[r] = '0;
        end
        modelHalted = 1'b0;
        expectRequest(resetPc, 16'h0000, 1'b0, 1'b1);

        @(posedge clk);
        arstN <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            compareFlag("memReq", 1'b0, memReq);
            compareFlag("halted", 1'b0, halted);
        end
        @(posedge clk);
        arstN <= 1'b1;

        while (!firstChecked) @(negedge clk);
        finishTest("reset: quiet bus in reset, first fetch at resetPc");

        while (halted !== 1'b1) @(negedge clk);
        compareFlag("halted", modelHalted, halted);
        if (expectQ.size() != 0) begin
            errors++;
            $display("The DUT halted with %0d expected requests never issued", expectQ.size());
        end
        $display("  %0d fetches, %0d loads, %0d stores, %0d jumps, %0d taken, %0d not taken",
                 fetches, loads, stores, jumps, taken, notTaken);
        finishTest("program: fetch addresses, loads, stores and branches");

        reqAtHalt = reqCount;
        repeat (quietCycles) begin
            @(negedge clk);
            compareFlag("memReq", 1'b0, memReq);
        end
        compareFlag("halted", 1'b1, halted);
        if (reqCount != reqAtHalt) begin
            errors++;
            $display("%0d memory requests were issued after halt", reqCount - reqAtHalt);
        end
        finishTest("halt: flag stays high and the bus stays quiet");

        assertFails = u_cpuTop.u_memHandshakeAssert.assertFails;
        if (assertFails != 0) begin
            errors += assertFails;
            $display("%0d handshake assertion failures were reported", assertFails);
        end
        finishTest("protocol: bound handshake assertions");

        $display("Tests: %0d run, %0d passed, %0d failed, %0d checks, %0d errors",
                 testsRun, testsRun - testsFailed, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/cpuPkg.sv
verilog/aluUnit.sv
verilog/registerFile.sv
verilog/cpuDatapath.sv
verilog/cpuController.sv
verilog/memoryPort.sv
verilog/cpuTop.sv
sim/memHandshake_assert.sv
sim/cpuTb.sv
